// ==== source/game_pkg.sv ====
package game_pkg;

  ////////////////////////////////////////////////////////////////////
  // Play field geometry
  ////////////////////////////////////////////////////////////////////

  // Maze size in tiles
  localparam int MAP_COLS = 28;
  localparam int MAP_ROWS = 36;

  // Tile edge in pixels
  localparam int TILE_SIZE = 8;

  // Visible play field in pixels
  localparam int H_VISIBLE = MAP_COLS * TILE_SIZE;
  localparam int V_VISIBLE = MAP_ROWS * TILE_SIZE;

  // Player block edge and start corner
  localparam int SPRITE_SIZE = 8;
  // Tile column 10, row 8, a floor tile
  localparam int START_X = 80;
  localparam int START_Y = 64;

  // Pixel coordinates, 8 and 9 bits
  typedef logic [$clog2(H_VISIBLE)-1:0] pos_x_t;
  typedef logic [$clog2(V_VISIBLE)-1:0] pos_y_t;

  ////////////////////////////////////////////////////////////////////
  // Colours and layers
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  localparam rgb_t WALL_COLOR   = '{red: 4'hF, green: 4'h0, blue: 4'h0};
  localparam rgb_t FLOOR_COLOR  = '{red: 4'h0, green: 4'h0, blue: 4'h0};
  localparam rgb_t PLAYER_COLOR = '{red: 4'hF, green: 4'hF, blue: 4'hF};

  // Mixer layer selection
  typedef enum logic [1:0] {
    layer_blank,
    layer_maze,
    layer_player
  } layer_t;

  // Fixed maze rule
  // Border ring plus a pillar wherever column and row are both 2 mod 4
  // Anything off the map also counts as wall
  function automatic logic tile_is_wall(input int col, input int row);
    logic off_map;
    logic border;
    logic pillar;
    off_map = (col < 0) || (col >= MAP_COLS) || (row < 0) || (row >= MAP_ROWS);
    border  = (col == 0) || (col == MAP_COLS - 1) || (row == 0) || (row == MAP_ROWS - 1);
    pillar  = ((col % 4) == 2) && ((row % 4) == 2);
    return off_map || border || pillar;
  endfunction

endpackage

// ==== source/scan_if.sv ====
// Scan position bundle shared by both renderers and the mixer
interface scan_if;

  // Current scan pixel, play field coordinates
  game_pkg::pos_x_t sx;
  game_pkg::pos_y_t sy;

  // One cycle pulse per frame
  logic frame_stb;

  // High inside the active video region
  logic display_enabled;

  // Renderers and mixer only ever read the scan
  modport renderer (
    input sx,
    input sy,
    input frame_stb,
    input display_enabled
  );

endinterface

// ==== source/maze_renderer.sv ====
module maze_renderer (
  input  logic             vga_pix_clk,
  input  logic             rst,
  scan_if.renderer         scan,
  output game_pkg::rgb_t   maze_color
);

  ////////////////////////////////////////////////////////////////////
  // Tile lookup
  ////////////////////////////////////////////////////////////////////

  // Tile coordinates of the current scan pixel
  int tile_col;
  int tile_row;

  // Wall answer for that tile
  logic tile_wall;

  always_comb begin
    // Divide down to tile units
    tile_col = int'(scan.sx) / game_pkg::TILE_SIZE;
    tile_row = int'(scan.sy) / game_pkg::TILE_SIZE;
  end

  // Pixels past the visible area still get an answer
  // the mixer blanks them later
  assign tile_wall = game_pkg::tile_is_wall(tile_col, tile_row);

  ////////////////////////////////////////////////////////////////////
  // Colour register
  ////////////////////////////////////////////////////////////////////

  // One cycle behind the scan, same as the player hit flag
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      maze_color <= game_pkg::FLOOR_COLOR;
    end else if (tile_wall) begin
      // Red wall
      maze_color <= game_pkg::WALL_COLOR;
    end else begin
      // Black floor
      maze_color <= game_pkg::FLOOR_COLOR;
    end
  end

endmodule

// ==== source/player_motion.sv ====
module player_motion (
  input  logic     vga_pix_clk,
  input  logic     rst,
  scan_if.renderer scan,
  input  logic     btn_up,
  input  logic     btn_down,
  input  logic     btn_left,
  input  logic     btn_right,
  output logic     player_hit
);

  // Top-left corner of the player block
  game_pkg::pos_x_t pos_x;
  game_pkg::pos_y_t pos_y;

  ////////////////////////////////////////////////////////////////////
  // Neighbour tile probes
  ////////////////////////////////////////////////////////////////////

  // Tile of the current position and its neighbours
  int cur_col;
  int cur_row;
  int up_row;
  int down_row;

  // Registered wall flags, one per direction
  logic wall_up;
  logic wall_down;
  logic wall_left;
  logic wall_right;

  always_comb begin
    cur_col  = int'(pos_x) / game_pkg::TILE_SIZE;
    cur_row  = int'(pos_y) / game_pkg::TILE_SIZE;
    // Vertical probes look one pixel past the corner
    up_row   = (int'(pos_y) - 1) / game_pkg::TILE_SIZE;
    down_row = (int'(pos_y) + 1) / game_pkg::TILE_SIZE;
  end

  // Refreshed every cycle so they are ready by the next strobe
  always_ff @(posedge vga_pix_clk) begin
    wall_up    <= game_pkg::tile_is_wall(cur_col, up_row);
    wall_down  <= game_pkg::tile_is_wall(cur_col, down_row);
    // Horizontal probes look a whole tile over
    wall_right <= game_pkg::tile_is_wall(cur_col + 1, cur_row);
    wall_left  <= game_pkg::tile_is_wall(cur_col - 1, cur_row);
  end

  ////////////////////////////////////////////////////////////////////
  // Movement, once per frame
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      pos_x <= game_pkg::pos_x_t'(game_pkg::START_X);
      pos_y <= game_pkg::pos_y_t'(game_pkg::START_Y);
    end else if (scan.frame_stb) begin
      // Down beats up
      if (btn_down) begin
        if (!wall_down) begin
          pos_y <= pos_y + 1'b1;
        end
      end else if (btn_up) begin
        if (!wall_up) begin
          pos_y <= pos_y - 1'b1;
        end
      end
      // Left beats right, a blocked left still holds the player
      if (btn_left) begin
        if (!wall_left) begin
          pos_x <= pos_x - 1'b1;
        end
      end else if (btn_right) begin
        if (!wall_right) begin
          pos_x <= pos_x + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Block drawing
  ////////////////////////////////////////////////////////////////////

  // Scan pixel inside the block
  logic in_x;
  logic in_y;

  // Compare in int so pos + size never wraps
  assign in_x = (int'(scan.sx) >= int'(pos_x)) &&
                (int'(scan.sx) <  int'(pos_x) + game_pkg::SPRITE_SIZE);
  assign in_y = (int'(scan.sy) >= int'(pos_y)) &&
                (int'(scan.sy) <  int'(pos_y) + game_pkg::SPRITE_SIZE);

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      player_hit <= 1'b0;
    end else begin
      player_hit <= in_x && in_y;
    end
  end

endmodule

// ==== source/pixel_mixer.sv ====
module pixel_mixer (
  input  logic           vga_pix_clk,
  input  logic           rst,
  scan_if.renderer       scan,
  input  game_pkg::rgb_t maze_color,
  input  logic           player_hit,
  output game_pkg::rgb_t pixel
);

  ////////////////////////////////////////////////////////////////////
  // Align scan qualifiers with the renderer outputs
  ////////////////////////////////////////////////////////////////////

  // Inside the 224x288 play field
  logic in_visible;

  // One cycle late copies
  logic display_q;
  logic visible_q;

  assign in_visible = (int'(scan.sx) < game_pkg::H_VISIBLE) &&
                      (int'(scan.sy) < game_pkg::V_VISIBLE);

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      display_q <= 1'b0;
      visible_q <= 1'b0;
    end else begin
      display_q <= scan.display_enabled;
      visible_q <= in_visible;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Layer pick and output register
  ////////////////////////////////////////////////////////////////////

  game_pkg::layer_t layer;

  // Blank first, then player over maze
  always_comb begin
    if (!display_q || !visible_q) begin
      layer = game_pkg::layer_blank;
    end else if (player_hit) begin
      layer = game_pkg::layer_player;
    end else begin
      layer = game_pkg::layer_maze;
    end
  end

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      pixel <= '0;
    end else begin
      case (layer)
        game_pkg::layer_player: pixel <= game_pkg::PLAYER_COLOR;
        game_pkg::layer_maze:   pixel <= maze_color;
        default:                pixel <= '0;
      endcase
    end
  end

endmodule

// ==== source/maze_game.sv ====
module maze_game (
  input  logic             vga_pix_clk,
  input  logic             rst,
  input  logic             frame_stb,
  input  game_pkg::pos_x_t sx,
  input  game_pkg::pos_y_t sy,
  input  logic             display_enabled,
  input  logic             btn_up,
  input  logic             btn_down,
  input  logic             btn_left,
  input  logic             btn_right,
  output logic [3:0]       red,
  output logic [3:0]       green,
  output logic [3:0]       blue
);

  ////////////////////////////////////////////////////////////////////
  // Scan bundle from the external timing generator
  ////////////////////////////////////////////////////////////////////

  scan_if scan ();

  assign scan.sx              = sx;
  assign scan.sy              = sy;
  assign scan.frame_stb       = frame_stb;
  assign scan.display_enabled = display_enabled;

  ////////////////////////////////////////////////////////////////////
  // Renderers and mixer
  ////////////////////////////////////////////////////////////////////

  // Renderer results, one cycle behind the scan
  game_pkg::rgb_t maze_color;
  logic           player_hit;

  // Final colour, two cycles behind the scan
  game_pkg::rgb_t pixel;

  maze_renderer maze_renderer_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .scan        (scan.renderer),
    .maze_color  (maze_color)
  );

  player_motion player_motion_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .scan        (scan.renderer),
    .btn_up      (btn_up),
    .btn_down    (btn_down),
    .btn_left    (btn_left),
    .btn_right   (btn_right),
    .player_hit  (player_hit)
  );

  pixel_mixer pixel_mixer_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .scan        (scan.renderer),
    .maze_color  (maze_color),
    .player_hit  (player_hit),
    .pixel       (pixel)
  );

  // Split onto the VGA colour pins
  assign red   = pixel.red;
  assign green = pixel.green;
  assign blue  = pixel.blue;

endmodule

// ==== testbench/maze_game_tb.sv ====
module maze_game_tb;

  // Clock and phase lengths
  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 10;
  localparam int FRAME_GAP    = 6;
  localparam int FRAME_LEN    = FRAME_GAP + 1;
  localparam int WINDOW_LEN   = 12 * 12;

  localparam int IDLE_CYCLES     = 400;
  localparam int BLANK_CYCLES    = 300;
  localparam int RIGHT_FRAMES    = 20;
  localparam int DOWN_FRAMES     = 20;
  localparam int UP_FRAMES       = 10;
  localparam int LEFT_FRAMES     = 120;
  localparam int OPPOSITE_FRAMES = 8;
  localparam int RANDOM_FRAMES   = 200;
  localparam int RANDOM_WINDOWS  = 4;

  localparam int MOVE_FRAMES = RIGHT_FRAMES + DOWN_FRAMES + UP_FRAMES + LEFT_FRAMES +
                               OPPOSITE_FRAMES + RANDOM_FRAMES;
  localparam int TEST_CYCLES = IDLE_CYCLES + BLANK_CYCLES + MOVE_FRAMES * FRAME_LEN +
                               (6 + RANDOM_WINDOWS) * WINDOW_LEN + 2;
  localparam int TIMEOUT = (RESET_CYCLES + TEST_CYCLES + 500) * CLK_PERIOD;

  // Left probe of tile column 1 hits the border column
  localparam int LEFT_STOP_X = 2 * game_pkg::TILE_SIZE - 1;

  // Button sets as {up, down, left, right}
  localparam logic [3:0] BTN_UP    = 4'b1000;
  localparam logic [3:0] BTN_DOWN  = 4'b0100;
  localparam logic [3:0] BTN_LEFT  = 4'b0010;
  localparam logic [3:0] BTN_RIGHT = 4'b0001;

  localparam logic [31:0] LFSR_SEED = 32'h41f4_db46;

  logic             vga_pix_clk;
  logic             rst;
  logic             frame_stb;
  game_pkg::pos_x_t sx;
  game_pkg::pos_y_t sy;
  logic             display_enabled;
  logic             btn_up;
  logic             btn_down;
  logic             btn_left;
  logic             btn_right;
  logic [3:0]       red;
  logic [3:0]       green;
  logic [3:0]       blue;

  // Reference player corner
  int model_x;
  int model_y;

  logic [31:0] lfsr_state;

  // Expected colours, two scan positions in flight
  game_pkg::rgb_t expected_q[$];

  int error_count;
  int check_count;

  maze_game maze_game_i (
    .vga_pix_clk     (vga_pix_clk),
    .rst             (rst),
    .frame_stb       (frame_stb),
    .sx              (sx),
    .sy              (sy),
    .display_enabled (display_enabled),
    .btn_up          (btn_up),
    .btn_down        (btn_down),
    .btn_left        (btn_left),
    .btn_right       (btn_right),
    .red             (red),
    .green           (green),
    .blue            (blue)
  );

  initial begin
    vga_pix_clk = 1'b0;
    forever #(CLK_PERIOD / 2) vga_pix_clk = ~vga_pix_clk;
  end

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  // Border ring, pillars at 2 mod 4, off map is wall
  function automatic logic tile_wall_ref(input int col, input int row);
    if (col < 0 || col >= 28 || row < 0 || row >= 36) begin
      return 1'b1;
    end
    if (col == 0 || col == 27 || row == 0 || row == 35) begin
      return 1'b1;
    end
    return (col % 4 == 2) && (row % 4 == 2);
  endfunction

  function automatic game_pkg::rgb_t expected_pixel(input int x, input int y, input logic de,
                                                    input int px, input int py);
    if (!de || x >= 224 || y >= 288) begin
      return '{red: 4'h0, green: 4'h0, blue: 4'h0};
    end
    // Player block drawn over the maze
    if (x >= px && x < px + 8 && y >= py && y < py + 8) begin
      return '{red: 4'hF, green: 4'hF, blue: 4'hF};
    end
    if (tile_wall_ref(x / 8, y / 8)) begin
      return '{red: 4'hF, green: 4'h0, blue: 4'h0};
    end
    return '{red: 4'h0, green: 4'h0, blue: 4'h0};
  endfunction

  // One strobe worth of movement
  task automatic apply_move(input logic [3:0] buttons);
    int   col;
    int   row;
    logic wall_u;
    logic wall_d;
    logic wall_l;
    logic wall_r;
    col    = model_x / 8;
    row    = model_y / 8;
    wall_u = tile_wall_ref(col, (model_y - 1) / 8);
    wall_d = tile_wall_ref(col, (model_y + 1) / 8);
    wall_l = tile_wall_ref(col - 1, row);
    wall_r = tile_wall_ref(col + 1, row);
    // Down over up
    if (buttons[2]) begin
      if (!wall_d) model_y = model_y + 1;
    end else if (buttons[3]) begin
      if (!wall_u) model_y = model_y - 1;
    end
    // Left over right, right ignored even when left is blocked
    if (buttons[1]) begin
      if (!wall_l) model_x = model_x - 1;
    end else if (buttons[0]) begin
      if (!wall_r) model_x = model_x + 1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int width, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < width; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  // Half the points close to the block, half anywhere visible
  task automatic choose_scan_point(output int x, output int y);
    logic [31:0] r;
    random_bits(1, r);
    if (r[0]) begin
      random_bits(4, r);
      x = model_x - 4 + int'(r[3:0]);
      random_bits(4, r);
      y = model_y - 4 + int'(r[3:0]);
    end else begin
      random_bits(8, r);
      x = int'(r[7:0]) % 224;
      random_bits(9, r);
      y = int'(r[8:0]) % 288;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  // Every post-reset cycle passes through here, keeps the queue aligned
  task automatic drive_cycle(input logic strobe, input int x, input int y, input logic de,
                             input logic [3:0] buttons);
    @(posedge vga_pix_clk);
    #DRIVE_DELAY;
    rst             = 1'b0;
    frame_stb       = strobe;
    sx              = game_pkg::pos_x_t'(x);
    sy              = game_pkg::pos_y_t'(y);
    display_enabled = de;
    {btn_up, btn_down, btn_left, btn_right} = buttons;
    // Position before this strobe draws this pixel
    expected_q.push_back(expected_pixel(int'(sx), int'(sy), de, model_x, model_y));
    if (strobe) apply_move(buttons);
  endtask

  task automatic sample_scene(input int cycles, input logic [3:0] buttons);
    int x;
    int y;
    for (int i = 0; i < cycles; i++) begin
      choose_scan_point(x, y);
      drive_cycle(1'b0, x, y, 1'b1, buttons);
    end
  endtask

  // Raw coordinates reach past 224x288, enable toggles
  task automatic sample_blanking(input int cycles);
    logic [31:0] rx;
    logic [31:0] ry;
    logic [31:0] rd;
    for (int i = 0; i < cycles; i++) begin
      random_bits(8, rx);
      random_bits(9, ry);
      random_bits(1, rd);
      drive_cycle(1'b0, int'(rx[7:0]), int'(ry[8:0]), rd[0], 4'b0000);
    end
  endtask

  task automatic steer_frames(input int frames, input logic [3:0] buttons, input logic shuffle);
    logic [31:0] r;
    logic [3:0]  held;
    int          x;
    int          y;
    held = buttons;
    for (int f = 0; f < frames; f++) begin
      if (shuffle) begin
        random_bits(4, r);
        held = r[3:0];
      end
      // Gap keeps the DUT wall probes fresh
      sample_scene(FRAME_GAP, held);
      choose_scan_point(x, y);
      drive_cycle(1'b1, x, y, 1'b1, held);
    end
  endtask

  // Block plus a two pixel ring, catches an off-by-one position
  task automatic scan_window();
    for (int dy = -2; dy < 10; dy++) begin
      for (int dx = -2; dx < 10; dx++) begin
        drive_cycle(1'b0, model_x + dx, model_y + dy, 1'b1, 4'b0000);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////

  task automatic check_pixel(input game_pkg::rgb_t expected, input game_pkg::rgb_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at time %0t: pixel colour expected %03h, got %03h",
               $time, expected, actual);
    end
  endtask

  // Outputs settle well before the falling edge
  initial begin : compare_outputs
    game_pkg::rgb_t expected;
    game_pkg::rgb_t actual;
    forever begin
      @(negedge vga_pix_clk);
      if (expected_q.size() > 2) begin
        expected = expected_q.pop_front();
        actual   = '{red: red, green: green, blue: blue};
        check_pixel(expected, actual);
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
    $display("Regression failed");
    $finish;
  end

  initial begin : main_sequence
    rst             = 1'b1;
    frame_stb       = 1'b0;
    sx              = '0;
    sy              = '0;
    display_enabled = 1'b0;
    btn_up          = 1'b0;
    btn_down        = 1'b0;
    btn_left        = 1'b0;
    btn_right       = 1'b0;
    lfsr_state      = LFSR_SEED;
    model_x         = game_pkg::START_X;
    model_y         = game_pkg::START_Y;
    error_count     = 0;
    check_count     = 0;

    // First drive_cycle supplies the last reset edge
    repeat (RESET_CYCLES - 1) @(posedge vga_pix_clk);

    // Maze and block at the start corner
    sample_scene(IDLE_CYCLES, 4'b0000);
    scan_window();

    // Blanking outside the field or with display off
    sample_blanking(BLANK_CYCLES);

    // Single held buttons
    steer_frames(RIGHT_FRAMES, BTN_RIGHT, 1'b0);
    scan_window();
    steer_frames(DOWN_FRAMES, BTN_DOWN, 1'b0);
    scan_window();
    steer_frames(UP_FRAMES, BTN_UP, 1'b0);
    scan_window();

    // Run into the left border and stay there
    steer_frames(LEFT_FRAMES, BTN_LEFT, 1'b0);
    scan_window();
    if (model_x != LEFT_STOP_X) begin
      error_count++;
      $display("Reference player did not stop at the left border, x is %0d", model_x);
    end

    // All four at once, blocked left still suppresses right
    steer_frames(OPPOSITE_FRAMES, BTN_UP | BTN_DOWN | BTN_LEFT | BTN_RIGHT, 1'b0);
    scan_window();

    // Random button sets
    for (int w = 0; w < RANDOM_WINDOWS; w++) begin
      steer_frames(RANDOM_FRAMES / RANDOM_WINDOWS, 4'b0000, 1'b1);
      scan_window();
    end

    // Push the last real pixels through the pipeline
    drive_cycle(1'b0, 0, 0, 1'b0, 4'b0000);
    drive_cycle(1'b0, 0, 0, 1'b0, 4'b0000);
    @(negedge vga_pix_clk);
    #1;

    $display("Pixel checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
source/game_pkg.sv
source/scan_if.sv
source/maze_renderer.sv
source/player_motion.sv
source/pixel_mixer.sv
source/maze_game.sv
testbench/maze_game_tb.sv

// ==== Makefile ====
# Verilator flow for the maze game testbench

VERILATOR ?= verilator
TOP       ?= maze_game_tb
RTL_TOP   ?= maze_game
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Regression passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
